// ==== files.f ====
hdl/lb_mem_pkg.sv
hdl/lb_mem_request_stage.sv
hdl/lb_mem_bus_master.sv
hdl/lb_mem_load_extract.sv
hdl/lb_axi_sram.sv
hdl/lb_mem_top.sv
test/lb_mem_assert.sv
test/lb_mem_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP       = lb_mem_tb
FILELIST  = files.f
SIMFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// ==== test/lb_mem_tb.sv ====
module lb_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lb_mem_pkg::*;

  localparam logic [1:0] K_FETCH = 2'd0;
  localparam logic [1:0] K_LOAD  = 2'd1;
  localparam logic [1:0] K_STORE = 2'd2;
  localparam logic [1:0] K_BOTH  = 2'd3;
  localparam int NROWS = 26;

  typedef struct packed {
    logic [1:0] kind;
    logic [2:0] funct;
    logic [9:0] addr;
    logic [3:0] stall;
  } row_t;

  logic            clk = 1'b0;
  logic            nrst;
  logic            i_f_valid, o_f_ready, o_f_valid;
  logic [XLEN-1:0] i_f_pc, o_f_inst;
  logic            i_d_valid, o_d_ready, i_d_we, o_d_valid, i_d_ready;
  logic [XLEN-1:0] i_d_addr, i_d_wdata, o_d_rdata;
  logic [2:0]      i_d_funct;

  int              errors = 0;
  logic [31:0]     rng = 32'hc52;
  logic [31:0]     shadow [MEM_WORDS] = '{default: '0};

  // Both requests in one row fetch from addr ^ 0x30
  row_t rows [NROWS] = '{
    '{K_STORE, FUNCT3_SW, 10'h010, 4'd0}, '{K_LOAD, FUNCT3_LW, 10'h010, 4'd0},
    '{K_LOAD, FUNCT3_LW, 10'h012, 4'd0}, '{K_STORE, FUNCT3_SW, 10'h020, 4'd0},
    '{K_STORE, FUNCT3_SB, 10'h021, 4'd0}, '{K_STORE, FUNCT3_SH, 10'h022, 4'd0},
    '{K_LOAD, FUNCT3_LB, 10'h020, 4'd0}, '{K_LOAD, FUNCT3_LB, 10'h021, 4'd0},
    '{K_LOAD, FUNCT3_LB, 10'h022, 4'd0}, '{K_LOAD, FUNCT3_LB, 10'h023, 4'd0},
    '{K_LOAD, FUNCT3_LBU, 10'h020, 4'd0}, '{K_LOAD, FUNCT3_LBU, 10'h021, 4'd0},
    '{K_LOAD, FUNCT3_LBU, 10'h022, 4'd0}, '{K_LOAD, FUNCT3_LBU, 10'h023, 4'd0},
    '{K_LOAD, FUNCT3_LH, 10'h020, 4'd0}, '{K_LOAD, FUNCT3_LH, 10'h022, 4'd0},
    '{K_LOAD, FUNCT3_LHU, 10'h020, 4'd0}, '{K_LOAD, FUNCT3_LHU, 10'h022, 4'd0},
    '{K_FETCH, FUNCT3_LW, 10'h010, 4'd0}, '{K_FETCH, FUNCT3_LW, 10'h3fc, 4'd0},
    '{K_BOTH, FUNCT3_LB, 10'h023, 4'd0}, '{K_BOTH, FUNCT3_LH, 10'h022, 4'd2},
    '{K_LOAD, FUNCT3_LW, 10'h010, 4'd3}, '{K_LOAD, FUNCT3_LBU, 10'h023, 4'd2},
    '{K_STORE, FUNCT3_SB, 10'h3ff, 4'd0}, '{K_LOAD, FUNCT3_LB, 10'h3ff, 4'd1}
  };

  always #2 clk = ~clk;

  lb_mem_top dut_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] load_expect(input logic [2:0] funct, input logic [9:0] addr);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow[addr[9:2]];
    b = w[{addr[1:0], 3'b000} +: 8];
    h = addr[1] ? w[31:16] : w[15:0];
    case (funct)
      FUNCT3_LB:  return {{24{b[7]}}, b};
      FUNCT3_LBU: return {24'd0, b};
      FUNCT3_LH:  return {{16{h[15]}}, h};
      FUNCT3_LHU: return {16'd0, h};
      default:    return w;
    endcase
  endfunction

  task automatic store_shadow(input logic [2:0] funct, input logic [9:0] addr,
                              input logic [31:0] data);
    case (funct)
      FUNCT3_SB: shadow[addr[9:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      FUNCT3_SH: shadow[addr[9:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
      default:   shadow[addr[9:2]] = data;
    endcase
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Entered on a falling edge, returns on the falling edge after acceptance
  task automatic issue_data(input logic we, input logic [2:0] funct,
                            input logic [31:0] addr, input logic [31:0] wdata);
    i_d_valid = 1'b1;
    i_d_we    = we;
    i_d_funct = funct;
    i_d_addr  = addr;
    i_d_wdata = wdata;
    #1;
    while (!o_d_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    i_d_valid = 1'b0;
  endtask

  task automatic issue_fetch(input logic [31:0] pc);
    i_f_valid = 1'b1;
    i_f_pc    = pc;
    #1;
    compare("o_f_ready", o_f_ready, 1);
    compare("o_d_ready", o_d_ready, 0);
    @(negedge clk);
    i_f_valid = 1'b0;
  endtask

  task automatic await_fetch(input logic [31:0] pc);
    #1;
    while (!o_f_valid) begin
      // Data port stays closed while the fetch is in flight
      compare("o_d_ready", o_d_ready, 0);
      @(negedge clk);
      #1;
    end
    compare("o_f_inst", o_f_inst, shadow[pc[MEM_AW+1:2]]);
    @(negedge clk);
  endtask

  task automatic await_load(input logic [31:0] exp, input int stall);
    logic [31:0] held;
    i_d_ready = (stall == 0);
    #1;
    while (!o_d_valid) begin
      @(negedge clk);
      #1;
    end
    held = o_d_rdata;
    compare("o_d_rdata", held, exp);
    // Response must sit still while the core stalls
    for (int k = 0; k < stall; k++) begin
      @(negedge clk);
      if (k == stall - 1) begin
        i_d_ready = 1'b1;
      end
      #1;
      compare("o_d_valid", o_d_valid, 1);
      compare("o_d_rdata", o_d_rdata, held);
      compare("o_f_ready", o_f_ready, 0);
    end
    @(negedge clk);
    #1;
    compare("o_d_valid", o_d_valid, 0);
    compare("o_f_ready", o_f_ready, 1);
    @(negedge clk);
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] addr;
    logic [31:0] wdata;
    addr = {22'd0, r.addr};
    #1;
    while (!o_f_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    case (r.kind)
      K_FETCH: begin
        issue_fetch(addr);
        await_fetch(addr);
      end
      K_STORE: begin
        rng = xorshift(rng);
        wdata = rng;
        store_shadow(r.funct, r.addr, wdata);
        issue_data(1'b1, r.funct, addr, wdata);
      end
      K_LOAD: begin
        issue_data(1'b0, r.funct, addr, '0);
        await_load(load_expect(r.funct, r.addr), r.stall);
      end
      default: begin
        i_d_valid = 1'b1;
        i_d_we    = 1'b0;
        i_d_funct = r.funct;
        i_d_addr  = addr;
        issue_fetch(addr ^ 32'h30);
        await_fetch(addr ^ 32'h30);
        issue_data(1'b0, r.funct, addr, '0);
        await_load(load_expect(r.funct, r.addr), r.stall);
      end
    endcase
  endtask

  initial begin
    nrst      = 1'b0;
    i_f_valid = 1'b0;
    i_f_pc    = '0;
    i_d_valid = 1'b0;
    i_d_addr  = '0;
    i_d_wdata = '0;
    i_d_we    = 1'b0;
    i_d_funct = 3'b000;
    i_d_ready = 1'b1;
    repeat (4) @(negedge clk);
    nrst = 1'b1;
    #1;
    compare("o_f_valid", o_f_valid, 0);
    compare("o_d_valid", o_d_valid, 0);
    compare("o_f_ready", o_f_ready, 1);
    @(negedge clk);
    for (int i = 0; i < NROWS; i++) begin
      run_row(rows[i]);
    end
    repeat (2) @(negedge clk);
    errors += dut_i.bus_i.assert_i.fail_count;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // One extra row of slack covers reset
  initial begin
    repeat ((NROWS + 1) * 20) @(posedge clk);
    $display("Run timed out after %0d cycles, errors so far: %0d", (NROWS + 1) * 20, errors);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== test/lb_mem_assert.sv ====
module lb_mem_assert (
  input logic clk,
  input logic nrst,
  input logic o_ar_valid,
  input logic i_ar_ready,
  input logic o_aw_valid,
  input logic o_w_valid,
  input logic i_r_valid,
  input logic i_b_valid,
  input logic o_req_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Single transfer in flight, so channels never overlap
  one_channel: assert property (@(posedge clk) disable iff (!nrst)
    $onehot0({o_ar_valid, o_aw_valid, o_w_valid, i_r_valid, i_b_valid}))
    else begin
      $error("more than one channel valid at once");
      fail_count++;
    end

  ar_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_ar_valid && !i_ar_ready |=> o_ar_valid)
    else begin
      $error("ar_valid dropped before ar_ready");
      fail_count++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (!nrst)
    o_req_done |=> !o_req_done)
    else begin
      $error("req_done high for more than one cycle");
      fail_count++;
    end

endmodule

bind lb_mem_bus_master lb_mem_assert assert_i (
  .clk(clk),
  .nrst(nrst),
  .o_ar_valid(o_ar_valid),
  .i_ar_ready(i_ar_ready),
  .o_aw_valid(o_aw_valid),
  .o_w_valid(o_w_valid),
  .i_r_valid(i_r_valid),
  .i_b_valid(i_b_valid),
  .o_req_done(o_req_done)
);

// ==== hdl/lb_mem_top.sv ====
module lb_mem_top (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_f_valid,
  output logic                        o_f_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_f_pc,
  output logic                        o_f_valid,
  output logic [lb_mem_pkg::XLEN-1:0] o_f_inst,
  input  logic                        i_d_valid,
  output logic                        o_d_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_d_addr,
  input  logic [lb_mem_pkg::XLEN-1:0] i_d_wdata,
  input  logic                        i_d_we,
  input  logic [2:0]                  i_d_funct,
  output logic                        o_d_valid,
  input  logic                        i_d_ready,
  output logic [lb_mem_pkg::XLEN-1:0] o_d_rdata
);
  import lb_mem_pkg::*;

  logic            req_valid, req_we, req_id, req_done;
  logic [XLEN-1:0] req_addr, req_wdata;
  logic [3:0]      req_wstrb;
  logic [2:0]      req_funct;
  logic [1:0]      req_lsb;

  logic            ar_valid, ar_ready, ar_id;
  logic [XLEN-1:0] ar_addr;
  logic            r_valid, r_ready, r_id;
  logic [XLEN-1:0] r_data;
  logic            aw_valid, aw_ready;
  logic [XLEN-1:0] aw_addr;
  logic            w_valid, w_ready;
  logic [XLEN-1:0] w_data;
  logic [3:0]      w_strb;
  logic            b_valid, b_ready;

  lb_mem_request_stage req_i (
    .clk, .nrst,
    .i_f_valid, .o_f_ready, .i_f_pc,
    .i_d_valid, .o_d_ready, .i_d_addr, .i_d_wdata, .i_d_we, .i_d_funct,
    .i_req_done(req_done), .o_req_valid(req_valid), .o_req_we(req_we),
    .o_req_id(req_id), .o_req_addr(req_addr), .o_req_wdata(req_wdata),
    .o_req_wstrb(req_wstrb), .o_req_funct(req_funct), .o_req_lsb(req_lsb)
  );

  lb_mem_bus_master bus_i (
    .clk, .nrst,
    .i_req_valid(req_valid), .i_req_we(req_we), .i_req_id(req_id),
    .i_req_addr(req_addr), .i_req_wdata(req_wdata), .i_req_wstrb(req_wstrb),
    .o_req_done(req_done),
    .o_ar_valid(ar_valid), .i_ar_ready(ar_ready), .o_ar_addr(ar_addr), .o_ar_id(ar_id),
    .o_aw_valid(aw_valid), .i_aw_ready(aw_ready), .o_aw_addr(aw_addr),
    .o_w_valid(w_valid), .i_w_ready(w_ready), .o_w_data(w_data), .o_w_strb(w_strb),
    .i_b_valid(b_valid), .o_b_ready(b_ready),
    .i_r_valid(r_valid), .i_r_ready(r_ready)
  );

  lb_mem_load_extract load_i (
    .i_r_valid(r_valid), .i_r_data(r_data), .i_r_id(r_id),
    .i_funct(req_funct), .i_lsb(req_lsb), .i_d_ready,
    .o_r_ready(r_ready), .o_f_valid, .o_f_inst, .o_d_valid, .o_d_rdata
  );

  lb_axi_sram sram_i (
    .clk, .nrst,
    .i_ar_valid(ar_valid), .o_ar_ready(ar_ready), .i_ar_addr(ar_addr), .i_ar_id(ar_id),
    .o_r_valid(r_valid), .i_r_ready(r_ready), .o_r_data(r_data), .o_r_id(r_id),
    .i_aw_valid(aw_valid), .o_aw_ready(aw_ready), .i_aw_addr(aw_addr),
    .i_w_valid(w_valid), .o_w_ready(w_ready), .i_w_data(w_data), .i_w_strb(w_strb),
    .o_b_valid(b_valid), .i_b_ready(b_ready)
  );

endmodule

// ==== hdl/lb_axi_sram.sv ====
module lb_axi_sram (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_ar_valid,
  output logic                        o_ar_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_ar_addr,
  input  logic                        i_ar_id,
  output logic                        o_r_valid,
  input  logic                        i_r_ready,
  output logic [lb_mem_pkg::XLEN-1:0] o_r_data,
  output logic                        o_r_id,
  input  logic                        i_aw_valid,
  output logic                        o_aw_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_aw_addr,
  input  logic                        i_w_valid,
  output logic                        o_w_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_w_data,
  input  logic [3:0]                  i_w_strb,
  output logic                        o_b_valid,
  input  logic                        i_b_ready
);
  import lb_mem_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WDATA,
    S_WAIT,
    S_RESP
  } sram_state_t;

  sram_state_t                     state;
  logic                            is_wr;
  logic [$clog2(SRAM_LAT+1)-1:0]   lat_cnt;
  logic [MEM_AW-1:0]               idx;
  lane_word_u                      w_lanes;
  lane_word_u                      merged;
  logic [XLEN-1:0]                 mem [MEM_WORDS] = '{default: '0};

  assign o_ar_ready = (state == S_IDLE);
  assign o_aw_ready = (state == S_IDLE) & ~i_ar_valid;
  assign o_w_ready  = (state == S_WDATA);
  assign o_r_valid  = (state == S_RESP) & ~is_wr;
  assign o_b_valid  = (state == S_RESP) & is_wr;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state   <= S_IDLE;
      is_wr   <= 1'b0;
      lat_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_ar_valid) begin
            state   <= S_WAIT;
            is_wr   <= 1'b0;
            lat_cnt <= ($bits(lat_cnt))'(SRAM_LAT);
          end else if (i_aw_valid) begin
            state <= S_WDATA;
            is_wr <= 1'b1;
          end
        end
        S_WDATA: begin
          if (i_w_valid) begin
            state   <= S_WAIT;
            lat_cnt <= ($bits(lat_cnt))'(SRAM_LAT);
          end
        end
        S_WAIT: begin
          if (lat_cnt == 'd1) state <= S_RESP;
          lat_cnt <= lat_cnt - 1'b1;
        end
        default: begin
          if (is_wr ? i_b_ready : i_r_ready) state <= S_IDLE;
        end
      endcase
    end
  end

  // Old word with the strobed byte lanes replaced
  assign w_lanes = i_w_data;
  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < 4; b++) begin
      if (i_w_strb[b]) merged.bytes[b] = w_lanes.bytes[b];
    end
  end

  always_ff @(posedge clk) begin
    if (o_ar_ready && i_ar_valid) begin
      idx    <= i_ar_addr[MEM_AW+1:2];
      o_r_id <= i_ar_id;
    end else if (o_aw_ready && i_aw_valid) begin
      idx <= i_aw_addr[MEM_AW+1:2];
    end
    if (o_w_ready && i_w_valid) mem[idx] <= merged.word;
    if (state == S_WAIT && lat_cnt == 'd1 && !is_wr) o_r_data <= mem[idx];
  end

endmodule

// ==== hdl/lb_mem_load_extract.sv ====
module lb_mem_load_extract (
  input  logic                        i_r_valid,
  input  logic [lb_mem_pkg::XLEN-1:0] i_r_data,
  input  logic                        i_r_id,
  input  logic [2:0]                  i_funct,
  input  logic [1:0]                  i_lsb,
  input  logic                        i_d_ready,
  output logic                        o_r_ready,
  output logic                        o_f_valid,
  output logic [lb_mem_pkg::XLEN-1:0] o_f_inst,
  output logic                        o_d_valid,
  output logic [lb_mem_pkg::XLEN-1:0] o_d_rdata
);
  import lb_mem_pkg::*;

  lane_word_u rd_lanes;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign rd_lanes = i_r_data;
  assign byte_sel = rd_lanes.bytes[i_lsb];
  assign half_sel = rd_lanes.halves[i_lsb[1]];

  always_comb begin
    case (i_funct)
      FUNCT3_LB:  o_d_rdata = {{24{byte_sel[7]}}, byte_sel};
      FUNCT3_LBU: o_d_rdata = {24'd0, byte_sel};
      FUNCT3_LH:  o_d_rdata = {{16{half_sel[15]}}, half_sel};
      FUNCT3_LHU: o_d_rdata = {16'd0, half_sel};
      default:    o_d_rdata = rd_lanes.word;
    endcase
  end

  assign o_f_inst  = i_r_data;
  assign o_f_valid = i_r_valid & (i_r_id == ID_FETCH);
  assign o_d_valid = i_r_valid & (i_r_id == ID_DATA);

  // Fetch responses are never stalled
  assign o_r_ready = i_r_valid & ((i_r_id == ID_FETCH) | i_d_ready);

endmodule

// ==== hdl/lb_mem_bus_master.sv ====
module lb_mem_bus_master (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_req_valid,
  input  logic                        i_req_we,
  input  logic                        i_req_id,
  input  logic [lb_mem_pkg::XLEN-1:0] i_req_addr,
  input  logic [lb_mem_pkg::XLEN-1:0] i_req_wdata,
  input  logic [3:0]                  i_req_wstrb,
  output logic                        o_req_done,
  output logic                        o_ar_valid,
  input  logic                        i_ar_ready,
  output logic [lb_mem_pkg::XLEN-1:0] o_ar_addr,
  output logic                        o_ar_id,
  output logic                        o_aw_valid,
  input  logic                        i_aw_ready,
  output logic [lb_mem_pkg::XLEN-1:0] o_aw_addr,
  output logic                        o_w_valid,
  input  logic                        i_w_ready,
  output logic [lb_mem_pkg::XLEN-1:0] o_w_data,
  output logic [3:0]                  o_w_strb,
  input  logic                        i_b_valid,
  output logic                        o_b_ready,
  input  logic                        i_r_valid,
  input  logic                        i_r_ready
);
  import lb_mem_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_AR,
    ST_R,
    ST_AW,
    ST_W,
    ST_B
  } bus_state_t;

  bus_state_t state_q;
  bus_state_t state_d;
  logic       r_fire;
  logic       b_fire;

  assign r_fire = (state_q == ST_R) & i_r_valid & i_r_ready;
  assign b_fire = (state_q == ST_B) & i_b_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_req_valid) begin
          state_d = i_req_we ? ST_AW : ST_AR;
        end
      end
      ST_AR: if (i_ar_ready) state_d = ST_R;
      ST_R:  if (r_fire) state_d = ST_IDLE;
      ST_AW: if (i_aw_ready) state_d = ST_W;
      ST_W:  if (i_w_ready) state_d = ST_B;
      ST_B:  if (b_fire) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Each channel is only active in its own state
  assign o_ar_valid = (state_q == ST_AR);
  assign o_aw_valid = (state_q == ST_AW);
  assign o_w_valid  = (state_q == ST_W);
  assign o_b_ready  = (state_q == ST_B);

  // Request is already word aligned
  assign o_ar_addr = i_req_addr;
  assign o_ar_id   = i_req_id;
  assign o_aw_addr = i_req_addr;
  assign o_w_data  = i_req_wdata;
  assign o_w_strb  = i_req_wstrb;

  // Releases the request stage on the last handshake
  assign o_req_done = r_fire | b_fire;

endmodule

// ==== hdl/lb_mem_request_stage.sv ====
module lb_mem_request_stage (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_f_valid,
  output logic                        o_f_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_f_pc,
  input  logic                        i_d_valid,
  output logic                        o_d_ready,
  input  logic [lb_mem_pkg::XLEN-1:0] i_d_addr,
  input  logic [lb_mem_pkg::XLEN-1:0] i_d_wdata,
  input  logic                        i_d_we,
  input  logic [2:0]                  i_d_funct,
  input  logic                        i_req_done,
  output logic                        o_req_valid,
  output logic                        o_req_we,
  output logic                        o_req_id,
  output logic [lb_mem_pkg::XLEN-1:0] o_req_addr,
  output logic [lb_mem_pkg::XLEN-1:0] o_req_wdata,
  output logic [3:0]                  o_req_wstrb,
  output logic [2:0]                  o_req_funct,
  output logic [1:0]                  o_req_lsb
);
  import lb_mem_pkg::*;

  logic       req_valid_q;
  logic       f_fire;
  logic       d_fire;
  lane_word_u st_lanes;
  logic [3:0] st_strb;

  // Fetch always wins, data waits for a quiet fetch port
  assign o_f_ready = ~req_valid_q;
  assign o_d_ready = ~req_valid_q & ~i_f_valid;
  assign f_fire    = i_f_valid & o_f_ready;
  assign d_fire    = i_d_valid & o_d_ready;

  // Narrow stores are copied onto every lane, the strobe picks the lane
  always_comb begin
    case (i_d_funct)
      FUNCT3_SB: st_lanes.bytes = {4{i_d_wdata[7:0]}};
      FUNCT3_SH: st_lanes.halves = {2{i_d_wdata[15:0]}};
      default:   st_lanes.word = i_d_wdata;
    endcase
  end

  always_comb begin
    st_strb = 4'b0000;
    if (i_d_we) begin
      case (i_d_funct)
        FUNCT3_SB: st_strb = 4'b0001 << i_d_addr[1:0];
        FUNCT3_SH: st_strb = i_d_addr[1] ? 4'b1100 : 4'b0011;
        default:   st_strb = 4'b1111;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      req_valid_q <= 1'b0;
    end else if (f_fire || d_fire) begin
      req_valid_q <= 1'b1;
    end else if (i_req_done) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_fire) begin
      o_req_we    <= 1'b0;
      o_req_id    <= ID_FETCH;
      o_req_addr  <= {i_f_pc[XLEN-1:2], 2'b00};
      o_req_wdata <= '0;
      o_req_wstrb <= 4'b0000;
      o_req_funct <= FUNCT3_LW;
      o_req_lsb   <= 2'b00;
    end else if (d_fire) begin
      o_req_we    <= i_d_we;
      o_req_id    <= ID_DATA;
      o_req_addr  <= {i_d_addr[XLEN-1:2], 2'b00};
      o_req_wdata <= st_lanes.word;
      o_req_wstrb <= st_strb;
      o_req_funct <= i_d_funct;
      o_req_lsb   <= i_d_addr[1:0];
    end
  end

  assign o_req_valid = req_valid_q;

endmodule

// ==== hdl/lb_mem_pkg.sv ====
package lb_mem_pkg;

  localparam int XLEN = 32;

  // RISC-V load and store width codes
  localparam logic [2:0] FUNCT3_LB  = 3'b000;
  localparam logic [2:0] FUNCT3_LH  = 3'b001;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_LBU = 3'b100;
  localparam logic [2:0] FUNCT3_LHU = 3'b101;
  localparam logic [2:0] FUNCT3_SB  = 3'b000;
  localparam logic [2:0] FUNCT3_SH  = 3'b001;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;

  // Transaction IDs on the read channels
  localparam logic ID_FETCH = 1'b0;
  localparam logic ID_DATA  = 1'b1;

  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;

  // Cycles from address (or write data) acceptance to response
  localparam int SRAM_LAT = 2;

  // One bus word seen as a whole, as byte lanes or as halfword lanes
  typedef union packed {
    logic [XLEN-1:0]  word;
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } lane_word_u;

endpackage
